//--- all.f
+incdir+hdl
hdl/icap_pkg.sv
hdl/boot_sequencer.sv
hdl/icap_port.sv
hdl/dip_store.sv
hdl/icap_multiboot_top.sv
dv/icap_multiboot_properties.sv
dv/tb_icap_multiboot.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f all.f --top-module tb_icap_multiboot -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
   exit 1
fi
exit 0

//--- dv/tb_icap_multiboot.sv
`timescale 1ns/1ps
`include "icap_consts.svh"

module tb_icap_multiboot;

   import icap_pkg::*;

   typedef struct packed
   {
      design_num_t dn;
      logic        pu;
      logic [3:0]  sw;
      icap_word_t  gen1;
      icap_word_t  gen2;
      icap_word_t  gen5;
   } reboot_row_t;

   // Powerup low rows expect the C3 readback in GENERAL_5 bits 7:4
   localparam reboot_row_t reboot_rows [8] = '{
      '{4'd0,  1'b0, 4'h0, 16'h0000, 16'h0300, 16'h00C0},
      '{4'd1,  1'b0, 4'h5, 16'h4000, 16'h0305, 16'h00C1},
      '{4'd2,  1'b1, 4'hA, 16'h8000, 16'h030A, 16'h00AA},
      '{4'd7,  1'b0, 4'h0, 16'hC000, 16'h0324, 16'h00C7},
      '{4'd11, 1'b1, 4'h6, 16'hC000, 16'h0339, 16'h0066},
      '{4'd12, 1'b0, 4'h0, 16'h0000, 16'h0300, 16'h00CC},
      '{4'd13, 1'b1, 4'h3, 16'h0000, 16'h0300, 16'h0033},
      '{4'd15, 1'b0, 4'hF, 16'h0000, 16'h0300, 16'h00CF}
   };

   logic        clk;
   logic        rst;
   design_num_t design_num;
   logic        reconfigure;
   logic        powerup;
   logic [3:0]  sw_in;
   logic [3:0]  sw_out;
   logic [3:0]  pwr_out;
   logic        initialized;
   icap_word_t  icap_din;
   logic        icap_ce_n;
   logic        icap_wr_n;
   icap_word_t  icap_dout = `ICAP_NULL;
   logic        icap_busy = 1'b1; // High whenever no read data is ready

   icap_word_t  write_log[$]; // Words seen by the port model
   logic [7:0]  readback_byte;
   logic        read_req;
   logic        read_active;
   int          stretch_left;
   int          error_count = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   bit          timed_out = 1'b0;

   icap_multiboot_top dut0
   (
      .clk         (clk),
      .rst         (rst),
      .design_num  (design_num),
      .reconfigure (reconfigure),
      .powerup     (powerup),
      .sw_in       (sw_in),
      .sw_out      (sw_out),
      .pwr_out     (pwr_out),
      .initialized (initialized),
      .icap_din    (icap_din),
      .icap_ce_n   (icap_ce_n),
      .icap_wr_n   (icap_wr_n),
      .icap_dout   (icap_dout),
      .icap_busy   (icap_busy)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Bit i of each byte sits at position 7-i on the pins
   function automatic icap_word_t reverse_byte_bits(input icap_word_t w);
      icap_word_t r;
      for (int i = 0; i < `ICAP_W; i++)
         r[i] = w[(i / 8) * 8 + 7 - (i % 8)];
      return r;
   endfunction

   // ------------------------------
   // ICAP model
   // ------------------------------

   always @(posedge clk)
   begin
      if (!rst && icap_ce_n === 1'b0 && icap_wr_n === 1'b0 &&
          reverse_byte_bits(icap_din) !== `ICAP_NULL)
         write_log.push_back(reverse_byte_bits(icap_din));
   end

   always @(posedge clk)
   begin
      read_req = !rst && icap_ce_n === 1'b0 && icap_wr_n === 1'b1;
      #5;
      if (!read_req)
      begin
         icap_busy   = 1'b1;
         icap_dout   = `ICAP_NULL;
         read_active = 1'b0;
      end
      else
      begin
         if (!read_active)
         begin
            read_active  = 1'b1;
            stretch_left = $urandom % 5; // 0 to 4 busy cycles
         end
         if (stretch_left == 0)
         begin
            icap_busy = 1'b0;
            icap_dout = reverse_byte_bits({8'h00, readback_byte});
         end
         else
            stretch_left--;
      end
   end

   // ------------------------------
   // Checks and waits
   // ------------------------------

   task automatic check_word(input string name, input icap_word_t got, input icap_word_t exp);
      if (got !== exp)
      begin
         error_count++;
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_sw(input string name, input logic [3:0] got, input logic [3:0] exp);
      if (got !== exp)
      begin
         error_count++;
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_stream(input string name, input icap_word_t exp[$]);
      if (write_log.size() != exp.size())
      begin
         error_count++;
         $display("%s: port saw %0d words instead of %0d", name, write_log.size(), exp.size());
      end
      for (int i = 0; i < exp.size() && i < write_log.size(); i++)
         check_word($sformatf("icap_din[%0d]", i), write_log[i], exp[i]);
   endtask

   task automatic wait_initialized(input logic level, input int limit, output int cycles);
      cycles = 0;
      if (timed_out)
         return; // Earlier timeout, skip the rest quickly
      while (initialized !== level)
      begin
         if (cycles == limit)
         begin
            timed_out = 1'b1;
            error_count++;
            $display("Timeout: initialized did not reach %0b in %0d cycles", level, limit);
            return;
         end
         @(posedge clk);
         #5;
         cycles++;
      end
   endtask

   task automatic report_test(input string name, input int base_err);
      tests_run++;
      if (error_count != base_err)
         tests_failed++;
      $display("test %s: %s", name, (error_count == base_err) ? "ok" : "failed");
   endtask

   // ------------------------------
   // Tests
   // ------------------------------

   task automatic run_startup(input string name, input logic [7:0] rb);
      icap_word_t exp[$];
      int         cycles;
      int         base_err;
      base_err      = error_count;
      readback_byte = rb;
      rst           = 1'b1;
      write_log.delete();
      repeat (4) @(posedge clk);
      #5;
      rst = 1'b0;
      wait_initialized(1'b1, 100, cycles);
      @(posedge clk); // Last NOOP is logged one edge after idle
      #5;
      exp = '{`ICAP_SYNC_H, `ICAP_SYNC_L, `ICAP_NOOP, `ICAP_NOOP, `ICAP_RD_GEN5,
              `ICAP_NOOP, `ICAP_NOOP, `ICAP_NOOP, `ICAP_NOOP,
              `ICAP_WR_CMD, `ICAP_CMD_DESYNC, `ICAP_NOOP, `ICAP_NOOP};
      check_stream(name, exp);
      report_test(name, base_err);
   endtask

   task automatic check_switches(input string name);
      int base_err;
      base_err = error_count;
      powerup  = 1'b0;
      sw_in    = 4'h9;
      #1;
      check_sw("sw_out", sw_out, readback_byte[3:0]);
      check_sw("pwr_out", pwr_out, readback_byte[7:4]);
      @(posedge clk);
      #5;
      powerup = 1'b1;
      #1;
      check_sw("sw_out", sw_out, 4'h9);
      check_sw("pwr_out", pwr_out, 4'h9);
      @(posedge clk);
      #5;
      powerup = 1'b0;
      report_test(name, base_err);
   endtask

   task automatic run_reboot(input int idx);
      reboot_row_t row;
      icap_word_t  exp[$];
      int          start_cycles;
      int          cycles;
      int          base_err;
      base_err    = error_count;
      row         = reboot_rows[idx];
      design_num  = row.dn;
      powerup     = row.pu;
      sw_in       = row.sw;
      write_log.delete();
      reconfigure = 1'b1;
      @(posedge clk); // This edge registers the request
      #5;
      reconfigure = 1'b0;
      wait_initialized(1'b0, 10, start_cycles);
      wait_initialized(1'b1, 40, cycles);
      if (!timed_out && start_cycles + cycles != 17)
      begin
         error_count++;
         $display("reboot %0d: back in idle %0d cycles after the request, not 17",
                  idx, start_cycles + cycles);
      end
      exp = '{`ICAP_SYNC_H, `ICAP_SYNC_L, `ICAP_WR_GEN1, row.gen1, `ICAP_WR_GEN2, row.gen2,
              `ICAP_WR_GEN5, row.gen5, `ICAP_WR_CMD, `ICAP_CMD_REBOOT,
              `ICAP_NOOP, `ICAP_NOOP, `ICAP_NOOP, `ICAP_NOOP};
      check_stream($sformatf("reboot_%0d", idx), exp);
      report_test($sformatf("reboot_%0d", idx), base_err);
   endtask

   initial
   begin
      void'($urandom(10));
      rst           = 1'b1;
      design_num    = '0;
      reconfigure   = 1'b0;
      powerup       = 1'b0;
      sw_in         = 4'h0;
      readback_byte = 8'h00;
      read_active   = 1'b0;
      stretch_left  = 0;

      run_startup("startup_5a", 8'h5A);
      check_switches("switches_5a");
      run_startup("startup_c3", 8'hC3);
      check_switches("switches_c3");
      for (int i = 0; i < 8; i++)
         run_reboot(i);

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
      if (error_count == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- dv/icap_multiboot_properties.sv
`timescale 1ns/1ps

module icap_multiboot_properties
(
   input logic clk,
   input logic rst,
   input logic cmd_ce_n,
   input logic cmd_wr_n,
   input logic busy,
   input logic latch_dip,
   input logic initialized
);

   // The port pins follow these one cycle later
   wr_n_moves_deselected: assert property (@(posedge clk) disable iff (rst)
      (cmd_wr_n != $past(cmd_wr_n)) |-> (cmd_ce_n && $past(cmd_ce_n)))
      else $error("cmd_wr_n changed while cmd_ce_n was low");

   idle_pattern: assert property (@(posedge clk) disable iff (rst)
      initialized |-> (!cmd_ce_n && !cmd_wr_n)) // Idle keeps writing null words
      else $error("initialized with cmd_ce_n or cmd_wr_n high");

   // Readback is taken only while the port holds a read
   latch_when_ready: assert property (@(posedge clk) disable iff (rst)
      latch_dip |-> $past(!cmd_ce_n && cmd_wr_n))
      else $error("latch_dip without a pending read on the port");

endmodule

bind boot_sequencer icap_multiboot_properties props0
(
   .clk         (clk),
   .rst         (rst),
   .cmd_ce_n    (cmd_ce_n),
   .cmd_wr_n    (cmd_wr_n),
   .busy        (busy),
   .latch_dip   (latch_dip),
   .initialized (initialized)
);

//--- hdl/icap_multiboot_top.sv
`timescale 1ns/1ps

module icap_multiboot_top
(
   input  logic                    clk,
   input  logic                    rst,
   input  icap_pkg::design_num_t   design_num,
   input  logic                    reconfigure,
   input  logic                    powerup,
   input  logic [3:0]              sw_in,
   output logic [3:0]              sw_out,
   output logic [3:0]              pwr_out,
   output logic                    initialized,
   output icap_pkg::icap_word_t    icap_din,
   output logic                    icap_ce_n,
   output logic                    icap_wr_n,
   input  icap_pkg::icap_word_t    icap_dout,
   input  logic                    icap_busy
);

   import icap_pkg::*;

   icap_word_t cmd_word;
   logic       cmd_ce_n;
   logic       cmd_wr_n;
   icap_word_t rd_word; // Readback in natural bit order
   logic       busy;
   logic       latch_dip;
   icap_word_t gen5_data;

   boot_sequencer seq0
   (
      .clk         (clk),
      .rst         (rst),
      .design_num  (design_num),
      .reconfigure (reconfigure),
      .busy        (busy),
      .gen5_data   (gen5_data),
      .cmd_word    (cmd_word),
      .cmd_ce_n    (cmd_ce_n),
      .cmd_wr_n    (cmd_wr_n),
      .latch_dip   (latch_dip),
      .initialized (initialized)
   );

   icap_port port0
   (
      .clk       (clk),
      .rst       (rst),
      .cmd_word  (cmd_word),
      .cmd_ce_n  (cmd_ce_n),
      .cmd_wr_n  (cmd_wr_n),
      .rd_word   (rd_word),
      .busy      (busy),
      .icap_din  (icap_din),
      .icap_ce_n (icap_ce_n),
      .icap_wr_n (icap_wr_n),
      .icap_dout (icap_dout),
      .icap_busy (icap_busy)
   );

   dip_store dip0
   (
      .clk        (clk),
      .rst        (rst),
      .latch_dip  (latch_dip),
      .rd_word    (rd_word),
      .powerup    (powerup),
      .sw_in      (sw_in),
      .design_num (design_num),
      .sw_out     (sw_out),
      .pwr_out    (pwr_out),
      .gen5_data  (gen5_data)
   );

endmodule

//--- hdl/dip_store.sv
`timescale 1ns/1ps
`include "icap_consts.svh"

module dip_store
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    latch_dip,
   input  icap_pkg::icap_word_t    rd_word,
   input  logic                    powerup,
   input  logic [3:0]              sw_in,
   input  icap_pkg::design_num_t   design_num,
   output logic [3:0]              sw_out,
   output logic [3:0]              pwr_out,
   output icap_pkg::icap_word_t    gen5_data
);

   import icap_pkg::*;

   logic [7:0] soft_dip; // Switch state read back from GENERAL_5

   always_ff @(posedge clk)
   begin
      if (rst)
         soft_dip <= 8'h00;
      else if (latch_dip)
         soft_dip <= rd_word[7:0];
   end

   // ------------------------------
   // Switch selection
   // ------------------------------

   // Physical switches win during powerup
   assign sw_out  = powerup ? sw_in : soft_dip[3:0];
   assign pwr_out = powerup ? sw_in : soft_dip[7:4];

   // Word stored in GENERAL_5 for the next image to read back
   assign gen5_data = {
      {(`ICAP_W - 8){1'b0}},
      (powerup ? sw_in : soft_dip[7:4]),
      (powerup ? sw_in : design_num)
   };

endmodule

//--- hdl/icap_port.sv
`timescale 1ns/1ps
`include "icap_consts.svh"

module icap_port
(
   input  logic                    clk,
   input  logic                    rst,
   input  icap_pkg::icap_word_t    cmd_word,
   input  logic                    cmd_ce_n,
   input  logic                    cmd_wr_n,
   output icap_pkg::icap_word_t    rd_word,
   output logic                    busy,
   output icap_pkg::icap_word_t    icap_din,
   output logic                    icap_ce_n,
   output logic                    icap_wr_n,
   input  icap_pkg::icap_word_t    icap_dout,
   input  logic                    icap_busy
);

   import icap_pkg::*;

   // The port takes D0 first, so each byte goes in MSB-first order
   function automatic icap_word_t byte_swizzle(input icap_word_t w);
      icap_word_t r;
      for (int b = 0; b < `ICAP_W / 8; b++)
         for (int i = 0; i < 8; i++)
            r[8*b + i] = w[8*b + 7 - i];
      return r;
   endfunction

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         icap_din  <= `ICAP_NULL;
         icap_ce_n <= 1'b1; // Port deselected
         icap_wr_n <= 1'b1;
      end
      else
      begin
         icap_din  <= byte_swizzle(cmd_word);
         icap_ce_n <= cmd_ce_n;
         icap_wr_n <= cmd_wr_n;
      end
   end

   assign rd_word = byte_swizzle(icap_dout); // Same mapping on the way back
   assign busy    = icap_busy;

endmodule

//--- hdl/boot_sequencer.sv
`timescale 1ns/1ps
`include "icap_consts.svh"

module boot_sequencer
(
   input  logic                    clk,
   input  logic                    rst,
   input  icap_pkg::design_num_t   design_num,
   input  logic                    reconfigure,
   input  logic                    busy,
   input  icap_pkg::icap_word_t    gen5_data,
   output icap_pkg::icap_word_t    cmd_word,
   output logic                    cmd_ce_n,
   output logic                    cmd_wr_n,
   output logic                    latch_dip,
   output logic                    initialized
);

   import icap_pkg::*;

   localparam int CNT_W = $clog2(`STARTUP_CYCLES + 1);

   logic [CNT_W-1:0] startup_cnt;
   logic             reconfigure_sync;
   seq_state_t       state;
   seq_state_t       next_state;

   // ------------------------------
   // State register and startup delay
   // ------------------------------

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state            <= init;
         startup_cnt      <= '0;
         reconfigure_sync <= 1'b0;
      end
      else
      begin
         reconfigure_sync <= reconfigure;
         if (startup_cnt != CNT_W'(`STARTUP_CYCLES))
         begin
            startup_cnt <= startup_cnt + 1'b1;
            state       <= init; // Hold until the port is ready
         end
         else
            state <= next_state;
      end
   end

   // ------------------------------
   // Next state and port pattern
   // ------------------------------

   always_comb
   begin
      next_state = seq_state_t'(state + 1'b1); // Most states step straight on
      cmd_ce_n   = 1'b0;
      cmd_wr_n   = 1'b0;
      cmd_word   = `ICAP_NULL;

      case (state)
         rd_dummy, dummy_2:
            cmd_word = `ICAP_SYNC_H;
         rd_sync_h, sync_h:
            cmd_word = `ICAP_SYNC_L;
         rd_sync_l, rd_noop_1, rd_gen5, rd_noop_3, rd_noop_4, rd_noop_5,
         rd_desync_l, rd_noop_7, rbt_l, rbt_noop_0, rbt_noop_1, rbt_noop_2:
            cmd_word = `ICAP_NOOP;
         rd_noop_2:
            cmd_word = `ICAP_RD_GEN5;

         // Read window, CE toggles around the WRITE change
         rd_noop_6, rd_avoid_abort_3:
            cmd_ce_n = 1'b1;
         rd_avoid_abort_1:
         begin
            cmd_ce_n = 1'b1;
            cmd_wr_n = 1'b1;
         end
         rd_avoid_abort_2:
            cmd_wr_n = 1'b1;
         rd_latch_data:
         begin
            cmd_wr_n = 1'b1;
            if (busy)
               next_state = rd_latch_data; // Wait for readback data
            else
               cmd_ce_n = 1'b1;
         end

         rd_avoid_abort_4, gen5_l:
            cmd_word = `ICAP_WR_CMD;
         rd_desync_h:
            cmd_word = `ICAP_CMD_DESYNC;

         idle:
            if (!reconfigure_sync)
               next_state = idle;

         sync_l:
            cmd_word = `ICAP_WR_GEN1;
         gen1_h:
            cmd_word = gen1_word(design_num);
         gen1_l:
            cmd_word = `ICAP_WR_GEN2;
         gen2_h:
            cmd_word = gen2_word(design_num);
         gen2_l:
            cmd_word = `ICAP_WR_GEN5;
         gen5_h:
            cmd_word = gen5_data;
         rbt_h:
            cmd_word = `ICAP_CMD_REBOOT;
         rbt_noop_3:
            next_state = idle;

         init, dummy_1:
            cmd_word = `ICAP_NULL;
         default:
            next_state = idle;
      endcase
   end

   assign latch_dip   = (state == rd_latch_data) && !busy; // Data valid with busy low
   assign initialized = (state == idle);

endmodule

//--- hdl/icap_pkg.sv
`include "icap_consts.svh"

package icap_pkg;

   typedef logic [`ICAP_W-1:0] icap_word_t;
   typedef logic [3:0] design_num_t; // Flash image selector

   // Readback states first, then the reboot states from idle onward
   typedef enum logic [5:0] {
      init, rd_dummy, rd_sync_h, rd_sync_l, rd_noop_1, rd_noop_2,
      rd_gen5, rd_noop_3, rd_noop_4, rd_noop_5, rd_noop_6,
      rd_avoid_abort_1, rd_avoid_abort_2, rd_latch_data,
      rd_avoid_abort_3, rd_avoid_abort_4, rd_desync_h, rd_desync_l,
      rd_noop_7, idle, dummy_1, dummy_2, sync_h, sync_l,
      gen1_h, gen1_l, gen2_h, gen2_l, gen5_h, gen5_l,
      rbt_h, rbt_l, rbt_noop_0, rbt_noop_1, rbt_noop_2, rbt_noop_3
   } seq_state_t;

   // GENERAL_1 holds the low address word, four images per 64K window
   function automatic icap_word_t gen1_word(input design_num_t dn);
      if (dn < 4'd12)
         return {dn[1:0], 14'b0};
      return 16'h0000;
   endfunction

   // GENERAL_2 holds the read opcode and upper address byte
   function automatic icap_word_t gen2_word(input design_num_t dn);
      case (dn)
         4'd0:    return 16'h0300;
         4'd1:    return 16'h0305;
         4'd2:    return 16'h030A;
         4'd3:    return 16'h030F;
         4'd4:    return 16'h0315;
         4'd5:    return 16'h031A;
         4'd6:    return 16'h031F;
         4'd7:    return 16'h0324;
         4'd8:    return 16'h032A;
         4'd9:    return 16'h032F;
         4'd10:   return 16'h0334;
         4'd11:   return 16'h0339;
         default: return 16'h0300; // Out of range falls back to image 0
      endcase
   endfunction

endpackage

//--- hdl/icap_consts.svh
`ifndef ICAP_CONSTS_SVH
`define ICAP_CONSTS_SVH

// ------------------------------
// Port geometry
// ------------------------------

`define ICAP_W 16 // Configuration port word width

// ------------------------------
// Packet words
// ------------------------------

// Sync pattern, sent as two words
`define ICAP_SYNC_H 16'hAA99
`define ICAP_SYNC_L 16'h5566

`define ICAP_NOOP 16'h2000 // Type 1 NOOP
`define ICAP_NULL 16'hFFFF // Dummy word, ignored by the port

// Type 1 headers, one word count each
`define ICAP_RD_GEN5 16'h2AE1 // Read GENERAL_5
`define ICAP_WR_GEN1 16'h3261 // Write GENERAL_1, address low
`define ICAP_WR_GEN2 16'h3281 // Write GENERAL_2, address high and opcode
`define ICAP_WR_GEN5 16'h32E1 // Write GENERAL_5, user word
`define ICAP_WR_CMD 16'h30A1  // Write CMD register

// CMD register codes
`define ICAP_CMD_DESYNC 16'h000D
`define ICAP_CMD_REBOOT 16'h000E

// ------------------------------
// Startup
// ------------------------------

// Cycles spent in INIT after reset before the readback starts
`define STARTUP_CYCLES 15

`endif
